//--- common/vdp_pkg.sv
package vdp_pkg;

    // ########################################################################
    // Frame timing, 640x480 at 800 clocks per line and 525 lines per frame.
    // ########################################################################

    localparam int h_total      = 800;
    localparam int v_total      = 525;
    localparam int h_active     = 640;
    localparam int v_active     = 480;

    // Sync pulse positions and lengths.
    localparam int h_sync_start = 656;
    localparam int h_sync_len   = 96;
    localparam int v_sync_start = 490;
    localparam int v_sync_len   = 2;

    // Raster counter widths.
    localparam int col_w        = 10;
    localparam int row_w        = 10;

    // ########################################################################
    // Picture window, 32x24 tiles of 8x8 pixels, each pixel doubled.
    // ########################################################################

    localparam int win_x0       = 64;
    localparam int win_y0       = 48;
    localparam int win_w        = 512;
    localparam int win_h        = 384;

    // Tile slot starts one tile ahead of the window.
    localparam int fetch_x0     = win_x0 - 16;

    // ########################################################################
    // Video RAM layout.
    // ########################################################################

    localparam int vram_aw      = 12;
    localparam int vram_dw      = 8;

    // Name table is 768 bytes, color table 32 bytes, pattern table 2 KB.
    localparam logic [vram_aw-1:0] name_base    = 12'h000;
    localparam logic [vram_aw-1:0] color_base   = 12'h300;
    localparam logic [vram_aw-1:0] pattern_base = 12'h800;

    // Border color code, bit 2 red, bit 1 green, bit 0 blue.
    localparam logic [3:0] border_color = 4'h1;

    // Clocks from raster position to pins.
    localparam int pipe_lat     = 2;

endpackage

//--- hw/vga_timing.sv
`timescale 1ns/10ps

module vga_timing import vdp_pkg::*; (
    input  logic             pxclk,
    input  logic             rst_n,
    output logic [col_w-1:0] col,
    output logic [row_w-1:0] row,
    output logic             hsync_raw,
    output logic             vsync_raw,
    output logic             active,
    output logic             window
);

    logic [col_w-1:0] col_nxt;
    logic [row_w-1:0] row_nxt;
    logic             line_end;
    logic             frame_end;

    // ########################################################################
    // Next raster position.
    // ########################################################################

    assign line_end  = (col == col_w'(h_total - 1));
    assign frame_end = (row == row_w'(v_total - 1));

    always_comb begin
        if (line_end) begin
            col_nxt = '0;
            if (frame_end) begin
                row_nxt = '0;
            end else begin
                row_nxt = row + row_w'(1);
            end
        end else begin
            col_nxt = col + col_w'(1);
            row_nxt = row;
        end
    end

    // ########################################################################
    // Counters and flags share one register stage.
    // ########################################################################

    // Flags are decoded from the next position so they match col and row.
    always_ff @(posedge pxclk or negedge rst_n) begin
        if (!rst_n) begin
            col       <= '0;
            row       <= '0;
            hsync_raw <= 1'b0;
            vsync_raw <= 1'b0;
            // Position 0,0 is visible and outside the picture.
            active    <= 1'b1;
            window    <= 1'b0;
        end else begin
            col       <= col_nxt;
            row       <= row_nxt;

            hsync_raw <= (col_nxt >= h_sync_start) &&
                         (col_nxt <  h_sync_start + h_sync_len);
            vsync_raw <= (row_nxt >= v_sync_start) &&
                         (row_nxt <  v_sync_start + v_sync_len);

            active    <= (col_nxt < h_active) && (row_nxt < v_active);

            window    <= (col_nxt >= win_x0) && (col_nxt < win_x0 + win_w) &&
                         (row_nxt >= win_y0) && (row_nxt < win_y0 + win_h);
        end
    end

endmodule

//--- hw/vdp_vram.sv
`timescale 1ns/10ps

module vdp_vram import vdp_pkg::*; (
    input  logic               pxclk,
    input  logic               rst_n,
    input  logic               we,
    input  logic [vram_aw-1:0] wr_addr,
    input  logic [vram_dw-1:0] wr_data,
    input  logic [vram_aw-1:0] rd_addr,
    output logic [vram_dw-1:0] rd_data
);

    logic [vram_dw-1:0] mem [0:(2**vram_aw)-1];

    // Host write port, taken on any clock.
    always_ff @(posedge pxclk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Renderer read port, one clock of latency.
    always_ff @(posedge pxclk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- vdp/vdp_tile_fetch.sv
`timescale 1ns/10ps

module vdp_tile_fetch import vdp_pkg::*; (
    input  logic               pxclk,
    input  logic               rst_n,
    input  logic [col_w-1:0]   col,
    input  logic [row_w-1:0]   row,
    input  logic [vram_dw-1:0] rd_data,
    output logic [vram_aw-1:0] rd_addr,
    output logic               tile_load,
    output logic [7:0]         tile_pattern,
    output logic [7:0]         tile_color
);

    logic [col_w-1:0] fx;
    logic [row_w-1:0] py;
    logic [4:0]       tile_col;
    logic [4:0]       char_row;
    logic [2:0]       char_line;
    logic             in_span;
    logic             in_rows;
    logic             load_span;
    logic [3:0]       phase;
    logic [7:0]       name_q;

    // ########################################################################
    // Look-ahead position.
    // ########################################################################

    // Slot j of the fetch span collects the bytes of tile j.
    assign fx        = col - col_w'(fetch_x0);
    assign py        = row - row_w'(win_y0);
    assign tile_col  = fx[8:4];
    assign char_row  = py[8:4];
    // Each pattern line is shown on two raster lines.
    assign char_line = py[3:1];

    assign in_span   = (col >= fetch_x0) && (col < fetch_x0 + win_w);
    assign in_rows   = (row >= win_y0) && (row < win_y0 + win_h);

    // Last clock of each slot ahead of a window tile.
    assign load_span = (col >= win_x0 - 1) && (col < win_x0 - 1 + win_w);

    // ########################################################################
    // Slot phase counter.
    // ########################################################################

    // Realigned once per line so phase 0 falls on each slot boundary.
    always_ff @(posedge pxclk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (col == col_w'(fetch_x0 - 1)) begin
            phase <= '0;
        end else begin
            phase <= phase + 4'd1;
        end
    end

    // ########################################################################
    // VRAM read sequence.
    // ########################################################################

    // Name at phase 0, pattern at phase 2, color at phase 4.
    always_comb begin
        case (phase)
            4'd2: begin
                rd_addr = pattern_base + {1'b0, name_q, char_line};
            end
            4'd4: begin
                // One color byte per group of 8 characters.
                rd_addr = color_base + {7'b0, name_q[7:3]};
            end
            default: begin
                rd_addr = name_base + {2'b0, char_row, tile_col};
            end
        endcase
    end

    // Bytes return one clock after their address.
    always_ff @(posedge pxclk) begin
        if (in_span && in_rows) begin
            case (phase)
                4'd1: begin
                    name_q <= rd_data;
                end
                4'd3: begin
                    tile_pattern <= rd_data;
                end
                4'd5: begin
                    tile_color <= rd_data;
                end
                default: begin
                end
            endcase
        end
    end

    // Pattern and color hold until phase 3 of the next slot, past the load.
    always_ff @(posedge pxclk or negedge rst_n) begin
        if (!rst_n) begin
            tile_load <= 1'b0;
        end else begin
            tile_load <= (phase == 4'd15) && load_span && in_rows;
        end
    end

endmodule

//--- vdp/vdp_pixel_out.sv
`timescale 1ns/10ps

module vdp_pixel_out import vdp_pkg::*; (
    input  logic       pxclk,
    input  logic       rst_n,
    input  logic       tile_load,
    input  logic [7:0] tile_pattern,
    input  logic [7:0] tile_color,
    input  logic       active,
    input  logic       window,
    input  logic       hsync_raw,
    input  logic       vsync_raw,
    output logic       red,
    output logic       grn,
    output logic       blu,
    output logic       hsync,
    output logic       vsync
);

    logic [7:0]          shift_q;
    logic [7:0]          color_q;
    logic                half_q;
    logic                active_q;
    logic                window_q;
    logic [pipe_lat-1:0] hs_pipe;
    logic [pipe_lat-1:0] vs_pipe;
    logic [2:0]          code;

    // ########################################################################
    // Stage 1, pattern shifter and delayed flags.
    // ########################################################################

    always_ff @(posedge pxclk or negedge rst_n) begin
        if (!rst_n) begin
            half_q   <= 1'b0;
            active_q <= 1'b0;
            window_q <= 1'b0;
            hs_pipe  <= '0;
            vs_pipe  <= '0;
        end else begin
            // Toggle restarts on each tile so bits are held 2 clocks.
            half_q   <= tile_load ? 1'b0 : ~half_q;
            active_q <= active;
            window_q <= window;
            hs_pipe  <= {hs_pipe[pipe_lat-2:0], hsync_raw};
            vs_pipe  <= {vs_pipe[pipe_lat-2:0], vsync_raw};
        end
    end

    // MSB first.
    always_ff @(posedge pxclk) begin
        if (tile_load) begin
            shift_q <= tile_pattern;
            color_q <= tile_color;
        end else if (half_q) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    // Bit 3 of every color code is ignored.
    always_comb begin
        if (!active_q) begin
            code = 3'b000;
        end else if (!window_q) begin
            code = border_color[2:0];
        end else if (shift_q[7]) begin
            code = color_q[6:4];
        end else begin
            code = color_q[2:0];
        end
    end

    // ########################################################################
    // Stage 2, RGB pins.
    // ########################################################################

    always_ff @(posedge pxclk or negedge rst_n) begin
        if (!rst_n) begin
            red <= 1'b0;
            grn <= 1'b0;
            blu <= 1'b0;
        end else begin
            red <= code[2];
            grn <= code[1];
            blu <= code[0];
        end
    end

    // Negative polarity syncs.
    assign hsync = ~hs_pipe[pipe_lat-1];
    assign vsync = ~vs_pipe[pipe_lat-1];

endmodule

//--- hw/vdp_top.sv
`timescale 1ns/10ps

module vdp_top import vdp_pkg::*; (
    input  logic               pxclk,
    input  logic               rst_n,
    input  logic               vram_we,
    input  logic [vram_aw-1:0] vram_addr,
    input  logic [vram_dw-1:0] vram_wdata,
    output logic               red,
    output logic               grn,
    output logic               blu,
    output logic               hsync,
    output logic               vsync
);

    // Raster position and flags.
    logic [col_w-1:0]   col;
    logic [row_w-1:0]   row;
    logic               hsync_raw;
    logic               vsync_raw;
    logic               active;
    logic               window;

    // Renderer read port.
    logic [vram_aw-1:0] rd_addr;
    logic [vram_dw-1:0] rd_data;

    // Tile handoff.
    logic               tile_load;
    logic [7:0]         tile_pattern;
    logic [7:0]         tile_color;

    vga_timing u_timing (
        .pxclk     (pxclk),
        .rst_n     (rst_n),
        .col       (col),
        .row       (row),
        .hsync_raw (hsync_raw),
        .vsync_raw (vsync_raw),
        .active    (active),
        .window    (window)
    );

    vdp_vram u_vram (
        .pxclk   (pxclk),
        .rst_n   (rst_n),
        .we      (vram_we),
        .wr_addr (vram_addr),
        .wr_data (vram_wdata),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    vdp_tile_fetch u_fetch (
        .pxclk        (pxclk),
        .rst_n        (rst_n),
        .col          (col),
        .row          (row),
        .rd_data      (rd_data),
        .rd_addr      (rd_addr),
        .tile_load    (tile_load),
        .tile_pattern (tile_pattern),
        .tile_color   (tile_color)
    );

    vdp_pixel_out u_pixel (
        .pxclk        (pxclk),
        .rst_n        (rst_n),
        .tile_load    (tile_load),
        .tile_pattern (tile_pattern),
        .tile_color   (tile_color),
        .active       (active),
        .window       (window),
        .hsync_raw    (hsync_raw),
        .vsync_raw    (vsync_raw),
        .red          (red),
        .grn          (grn),
        .blu          (blu),
        .hsync        (hsync),
        .vsync        (vsync)
    );

endmodule

//--- testbench/tb_vdp_tasks.svh
`ifndef TB_VDP_TASKS_SVH
`define TB_VDP_TASKS_SVH

// ############################################################################
// Failure reporting and compares.
// ############################################################################

task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error.");
endtask

task automatic check_rgb(input string name, input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp) begin
        stop_with_failure($sformatf("FAILED %s got %h expected %h at col %0d row %0d",
                                    name, got, exp, out_col, out_row));
    end
endtask

task automatic check_sync(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        stop_with_failure($sformatf("FAILED %s got %h expected %h at col %0d row %0d",
                                    name, got, exp, out_col, out_row));
    end
endtask

task automatic check_idle_outputs();
    check_sync("hsync", hsync, 1'b1);
    check_sync("vsync", vsync, 1'b1);
    check_rgb("rgb", {red, grn, blu}, 3'b000);
endtask

// ############################################################################
// Host write port.
// ############################################################################

task automatic vram_write(input int addr, input logic [7:0] data);
    @(posedge pxclk);
    vram_we    <= 1'b1;
    vram_addr  <= vram_aw'(addr);
    vram_wdata <= data;
    vram_model[addr] = data;
endtask

// Ends on a falling edge, where the sampler expects to start.
task automatic vram_write_end();
    @(posedge pxclk);
    vram_we <= 1'b0;
    @(negedge pxclk);
endtask

task automatic fill_vram();
    for (int a = 0; a < 2**vram_aw; a++) begin
        vram_write(a, 8'(a) ^ {a[11:8], a[11:8]});
    end
endtask

// ############################################################################
// Reference picture and frame sampler.
// ############################################################################

function automatic logic [2:0] expected_rgb(input int c, input int r);
    int         x;
    int         y;
    logic [7:0] name;
    logic [7:0] pat;
    logic [7:0] clr;
    logic [3:0] code;
    if (c >= h_active || r >= v_active) begin
        return 3'b000;
    end
    if (c < win_x0 || c >= win_x0 + win_w || r < win_y0 || r >= win_y0 + win_h) begin
        return border_color[2:0];
    end
    x    = c - win_x0;
    y    = r - win_y0;
    name = vram_model[int'(name_base) + (y / 16) * 32 + x / 16];
    pat  = vram_model[int'(pattern_base) + int'(name) * 8 + (y / 2) % 8];
    clr  = vram_model[int'(color_base) + int'(name) / 8];
    // Each pattern bit covers two clocks, MSB first.
    code = pat[7 - (x % 16) / 2] ? clr[7:4] : clr[3:0];
    return code[2:0];
endfunction

// Called on a falling edge; returns on the first output clock of vsync.
task automatic wait_frame_start();
    while (vsync !== 1'b1) begin
        @(negedge pxclk);
    end
    while (vsync !== 1'b0) begin
        @(negedge pxclk);
    end
    out_col = 0;
    out_row = v_sync_start;
endtask

task automatic check_frame(input bit do_sync, input bit do_border, input bit do_win);
    bit   in_win;
    logic hs_exp;
    logic vs_exp;
    wait_frame_start();
    for (int i = 0; i < frame_clks; i++) begin
        in_win = (out_col >= win_x0) && (out_col < win_x0 + win_w) &&
                 (out_row >= win_y0) && (out_row < win_y0 + win_h);
        if (do_sync) begin
            hs_exp = (out_col >= h_sync_start && out_col < h_sync_start + h_sync_len) ?
                     1'b0 : 1'b1;
            vs_exp = (out_row >= v_sync_start && out_row < v_sync_start + v_sync_len) ?
                     1'b0 : 1'b1;
            check_sync("hsync", hsync, hs_exp);
            check_sync("vsync", vsync, vs_exp);
        end
        if ((do_border && !in_win) || (do_win && in_win)) begin
            check_rgb("rgb", {red, grn, blu}, expected_rgb(out_col, out_row));
        end
        // Stop on the last clock of the frame so the next scan starts at once.
        if (i < frame_clks - 1) begin
            @(negedge pxclk);
            out_col++;
            if (out_col == h_total) begin
                out_col = 0;
                out_row = (out_row + 1) % v_total;
            end
        end
    end
endtask

`endif

//--- testbench/tb_vdp_top.sv
`timescale 1ns/10ps

module tb_vdp_top import vdp_pkg::*; ();

    logic               pxclk = 1'b0;
    logic               rst_n;
    logic               vram_we;
    logic [vram_aw-1:0] vram_addr;
    logic [vram_dw-1:0] vram_wdata;
    logic               red;
    logic               grn;
    logic               blu;
    logic               hsync;
    logic               vsync;

    // Copy of the VRAM contents as the host wrote them.
    logic [7:0]  vram_model [0:(2**vram_aw)-1];
    logic [15:0] lfsr_state;

    // Output position rebuilt from the vsync edge.
    int out_col;
    int out_row;

    localparam int frame_clks   = h_total * v_total;
    // Five frame scans, each after at most one frame of wait, plus the VRAM loads.
    localparam int timeout_clks = 11 * frame_clks + 2 * (2**vram_aw) + 1000;

    vdp_top DUT (
        .pxclk      (pxclk),
        .rst_n      (rst_n),
        .vram_we    (vram_we),
        .vram_addr  (vram_addr),
        .vram_wdata (vram_wdata),
        .red        (red),
        .grn        (grn),
        .blu        (blu),
        .hsync      (hsync),
        .vsync      (vsync)
    );

    `include "tb_vdp_tasks.svh"

    always #2 pxclk = ~pxclk;

    initial begin
        repeat (timeout_clks) @(posedge pxclk);
        stop_with_failure("Timeout, the test sequence did not finish in time.");
    end

    // ########################################################################
    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1.
    // ########################################################################

    function automatic logic lfsr_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr_bit()};
        end
        return b;
    endfunction

    // ########################################################################
    // Directed tests.
    // ########################################################################

    task automatic test_reset_state();
        @(negedge pxclk);
        check_idle_outputs();
        @(posedge pxclk);
        rst_n <= 1'b1;
        @(negedge pxclk);
        check_idle_outputs();
        // First clock with reset released.
        @(negedge pxclk);
        check_idle_outputs();
    endtask

    task automatic test_char_render();
        logic [7:0] glyph [8];
        glyph = '{8'h81, 8'h42, 8'h24, 8'h18, 8'hF0, 8'h0F, 8'hAA, 8'h55};
        fill_vram();
        // Character 0x41 at character row 5, tile column 9.
        vram_write(int'(name_base) + 5 * 32 + 9, 8'h41);
        for (int i = 0; i < 8; i++) begin
            vram_write(int'(pattern_base) + 8'h41 * 8 + i, glyph[i]);
        end
        // Low nibble 0xA checks that bit 3 is dropped.
        vram_write(int'(color_base) + 8'h41 / 8, 8'h6A);
        vram_write_end();
        check_frame(1'b0, 1'b0, 1'b1);
    endtask

    task automatic test_color_groups();
        logic [7:0] chars [4];
        logic [7:0] colors [4];
        chars  = '{8'h08, 8'h10, 8'h88, 8'hF8};
        colors = '{8'h12, 8'h34, 8'h56, 8'h71};
        for (int k = 0; k < 4; k++) begin
            vram_write(int'(name_base) + 10 * 32 + k, chars[k]);
            for (int i = 0; i < 8; i++) begin
                vram_write(int'(pattern_base) + int'(chars[k]) * 8 + i, 8'hF0);
            end
            vram_write(int'(color_base) + int'(chars[k]) / 8, colors[k]);
        end
        vram_write_end();
        check_frame(1'b0, 1'b0, 1'b1);
    endtask

    task automatic test_random_fill();
        for (int a = 0; a < 768; a++) begin
            vram_write(int'(name_base) + a, random_byte());
        end
        for (int a = 0; a < 32; a++) begin
            vram_write(int'(color_base) + a, random_byte());
        end
        for (int a = 0; a < 2048; a++) begin
            vram_write(int'(pattern_base) + a, random_byte());
        end
        vram_write_end();
        check_frame(1'b1, 1'b1, 1'b1);
    endtask

    initial begin
        rst_n      = 1'b0;
        vram_we    = 1'b0;
        vram_addr  = '0;
        vram_wdata = '0;
        lfsr_state = 16'd38357;
        out_col    = 0;
        out_row    = 0;

        test_reset_state();
        // Sync pulses, then border and blanking, over full frames.
        check_frame(1'b1, 1'b0, 1'b0);
        check_frame(1'b0, 1'b1, 1'b0);
        test_char_render();
        test_color_groups();
        test_random_fill();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- build.f
+incdir+testbench
common/vdp_pkg.sv
hw/vga_timing.sv
hw/vdp_vram.sv
vdp/vdp_tile_fetch.sv
vdp/vdp_pixel_out.sv
hw/vdp_top.sv
testbench/tb_vdp_top.sv

//--- Makefile
TOP := tb_vdp_top
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
